// ==== Makefile ====
# Verilator build and run of the GMII transmit MAC testbench

VERILATOR ?= verilator
TOP       ?= tb_gmii_tx_mac
FILELIST  ?= gmii_tx_mac.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --assert -j 0

.PHONY: sim clean

# pass only if the run prints the pass message
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

// ==== gmii_tx_mac.f ====
verilog/mac_pkg.sv
verilog/tx_pipe_pkg.sv
verilog/tx_byte_store.sv
verilog/tx_frame_sequencer.sv
verilog/tx_fcs_inserter.sv
verilog/gmii_tx_mac.sv
verif/gmii_tx_mac_assert.sv
verif/gmii_tx_checker.sv
verif/tb_gmii_tx_mac.sv

// ==== verif/gmii_tx_checker.sv ====
`default_nettype none

module gmii_tx_checker #(
    parameter int gap_cycles = 12
) (
    input  wire       clock,
    input  wire       reset,
    input  wire       host_valid,
    input  wire [7:0] host_data,
    input  wire       host_last,
    input  wire       credit_return,
    input  wire [7:0] tx_data,
    input  wire       tx_en,
    input  wire       test_end,
    input  int        test_id,
    output int        error_count,
    output int        frames_checked,
    output int        pending
);

    logic [7:0]  exp_bytes[$];                        // payload in write order
    int          exp_len[$];
    logic [31:0] exp_fcs[$];                          // already complemented
    logic [7:0]  cur_data[$];                         // frame now on the wire
    logic [31:0] crc_run;
    logic [31:0] cur_fcs;
    logic [7:0]  expect_byte;
    logic        tx_en_q;
    logic        seen_frame;
    logic        any_written;
    int          host_len;
    int          cur_len;
    int          pos;
    int          idle_run;
    int          written;
    int          returned;
    int          frames_at_start;
    int          errors_at_start;

    // reflected CRC-32, one bit at a time
    function automatic logic [31:0] crc_bitwise(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++)
            c = {1'b0, c[31:1]} ^ ((c[0] ^ data[i]) ? 32'hedb8_8320 : 32'h0);
        return c;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset";
            2:       return "random frames";
            3:       return "back-pressure burst";
            default: return "credit balance";
        endcase
    endfunction

    always @(posedge clock)
    begin
        if (!any_written && (tx_en !== 1'b0 || credit_return !== 1'b0))
        begin
            $display("output active before any frame was written");
            error_count++;
        end

        if (reset)
        begin
            any_written     = 1'b0;
            crc_run         = 32'hffff_ffff;
            tx_en_q         = 1'b0;
            seen_frame      = 1'b0;
            host_len        = 0;
            cur_len         = 0;
            pos             = 0;
            idle_run        = 0;
            written         = 0;
            returned        = 0;
            frames_checked  = 0;
            frames_at_start = 0;
            errors_at_start = 0;
        end
        else
        begin
            //--------------------------------------------------------------
            // host side model
            //--------------------------------------------------------------
            if (host_valid)
            begin
                any_written = 1'b1;
                written++;
                exp_bytes.push_back(host_data);
                crc_run = crc_bitwise(crc_run, host_data);
                host_len++;
                if (host_last)
                begin
                    exp_len.push_back(host_len);
                    exp_fcs.push_back(~crc_run);
                    crc_run  = 32'hffff_ffff;
                    host_len = 0;
                end
            end
            if (credit_return)
                returned++;

            //--------------------------------------------------------------
            // GMII side
            //--------------------------------------------------------------
            if (tx_en && !tx_en_q)                    // frame start
            begin
                if (seen_frame && idle_run < gap_cycles)
                begin
                    $display("interframe gap of %0d cycles is below %0d", idle_run, gap_cycles);
                    error_count++;
                end
                cur_data.delete();
                if (exp_len.size() == 0)
                begin
                    $display("frame sent that was never written");
                    error_count++;
                    cur_len = 0;
                end
                else
                begin
                    cur_len = exp_len.pop_front();
                    cur_fcs = exp_fcs.pop_front();
                    for (int i = 0; i < cur_len; i++)
                        cur_data.push_back(exp_bytes.pop_front());
                end
                pos        = 0;
                seen_frame = 1'b1;
            end

            if (tx_en)
            begin
                if (pos < 7)
                    expect_byte = 8'h55;
                else if (pos == 7)
                    expect_byte = 8'hd5;
                else if (pos < 8 + cur_len)
                    expect_byte = cur_data[pos - 8];
                else
                    expect_byte = 8'(cur_fcs >> (8 * (pos - 8 - cur_len)));  // low byte first

                if (pos == 12 + cur_len)
                begin
                    $display("frame longer than its %0d written bytes", cur_len);
                    error_count++;
                end
                else if (pos < 12 + cur_len && tx_data !== expect_byte)
                begin
                    $display("Fail tx_data frame %0d byte %0d: got %h expected %h",
                             frames_checked, pos, tx_data, expect_byte);
                    error_count++;
                end
                pos++;
                idle_run = 0;
            end
            else
            begin
                if (tx_en_q && pos < 12 + cur_len)
                begin
                    $display("frame ended early after %0d of %0d bytes", pos, 12 + cur_len);
                    error_count++;
                end
                else if (tx_en_q && pos == 12 + cur_len)
                    frames_checked++;
                idle_run++;
            end
            tx_en_q = tx_en;

            if (test_end)
            begin
                if (returned != written)
                begin
                    $display("Fail credit_return count: got %h expected %h", returned, written);
                    error_count++;
                end
                $display("test %0d %s: %0d frames, %0d errors", test_id, test_name(test_id),
                         frames_checked - frames_at_start, error_count - errors_at_start);
                frames_at_start = frames_checked;
                errors_at_start = error_count;
            end
        end
        pending = exp_len.size();
    end

endmodule

`default_nettype wire

// ==== verif/gmii_tx_mac_assert.sv ====
`default_nettype none

module gmii_tx_mac_assert #(
    parameter int fifo_depth = 32
) (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        host_valid,
    input  wire                        pop,
    input  wire                        frame_ready,
    input  wire [$clog2(fifo_depth):0] wr_ptr,
    input  wire [$clog2(fifo_depth):0] rd_ptr
);

    localparam int                 addr_bits  = $clog2(fifo_depth);
    localparam logic [addr_bits:0] full_level = (addr_bits + 1)'(fifo_depth);

    logic [addr_bits:0] used;                         // bytes held

    assign used = wr_ptr - rd_ptr;

    no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        host_valid |-> used != full_level)
        else $error("byte store written while full");

    no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
        pop |-> used != '0)
        else $error("byte store popped while empty");

    ready_needs_data: assert property (@(posedge clock) disable iff (reset)
        frame_ready |-> used != '0)
        else $error("frame_ready high with an empty byte store");

endmodule

bind tx_byte_store gmii_tx_mac_assert #(
    .fifo_depth  (fifo_depth)
) i_assert (
    .clock       (clock),
    .reset       (reset),
    .host_valid  (host_valid),
    .pop         (pop),
    .frame_ready (frame_ready),
    .wr_ptr      (wr_ptr),
    .rd_ptr      (rd_ptr)
);

`default_nettype wire

// ==== verif/tb_gmii_tx_mac.sv ====
`default_nettype none

module tb_gmii_tx_mac;

    localparam int fifo_depth     = 32;
    localparam int gap_cycles     = 12;
    localparam int random_frames  = 20;
    localparam int burst_frames   = 6;
    localparam int short_frames   = 10;
    localparam int total_frames   = random_frames + burst_frames + short_frames;
    localparam int timeout_cycles = total_frames * (2 * fifo_depth + 16 + gap_cycles) + 200;

    logic        clock;
    logic        reset;
    logic        host_valid;
    logic [7:0]  host_data;
    logic        host_last;
    logic        credit_return;
    logic [7:0]  tx_data;
    logic        tx_en;

    logic        test_end;
    int          test_id;
    int          error_count;
    int          frames_checked;
    int          pending;                             // frames written but not yet started

    logic [31:0] rng_state;
    int          credits_used;                        // bytes written
    int          credits_back;                        // credit_return pulses
    int          cycles = 0;

    gmii_tx_mac #(
        .fifo_depth     (fifo_depth),
        .gap_cycles     (gap_cycles)
    ) i_dut (
        .clock          (clock),
        .reset          (reset),
        .host_valid     (host_valid),
        .host_data      (host_data),
        .host_last      (host_last),
        .credit_return  (credit_return),
        .tx_data        (tx_data),
        .tx_en          (tx_en)
    );

    gmii_tx_checker #(
        .gap_cycles     (gap_cycles)
    ) i_checker (
        .clock          (clock),
        .reset          (reset),
        .host_valid     (host_valid),
        .host_data      (host_data),
        .host_last      (host_last),
        .credit_return  (credit_return),
        .tx_data        (tx_data),
        .tx_en          (tx_en),
        .test_end       (test_end),
        .test_id        (test_id),
        .error_count    (error_count),
        .frames_checked (frames_checked),
        .pending        (pending)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    always @(posedge clock)
    begin
        if (reset)
            credits_back <= 0;
        else if (credit_return)
            credits_back <= credits_back + 1;
    end

    //----------------------------------------------------------------------
    // stimulus helpers
    //----------------------------------------------------------------------

    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);    // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // called on a rising edge, returns on the edge that takes the byte
    task automatic write_byte(input logic [7:0] data, input logic last);
        while (credits_used - credits_back >= fifo_depth)
        begin
            host_valid <= 1'b0;                       // no credit, host stalls
            @(posedge clock);
        end
        host_valid <= 1'b1;
        host_data  <= data;
        host_last  <= last;
        credits_used = credits_used + 1;
        @(posedge clock);
    endtask

    task automatic send_frame(input int len, input logic with_idles);
        logic [31:0] r;
        for (int i = 0; i < len; i++)
        begin
            r = rand_next();
            if (with_idles && r[1:0] == 2'b00)
            begin
                host_valid <= 1'b0;                   // one host idle cycle
                @(posedge clock);
            end
            write_byte(r[15:8], i == len - 1);
        end
    endtask

    // wait until every written frame has left the MAC, then tell the checker
    task automatic finish_test(input int id);
        host_valid <= 1'b0;
        repeat (2) @(negedge clock);
        while (pending != 0 || tx_en)
            @(negedge clock);
        @(posedge clock);
        test_end <= 1'b1;
        test_id  <= id;
        @(posedge clock);
        test_end <= 1'b0;
    endtask

    //----------------------------------------------------------------------
    // test sequence
    //----------------------------------------------------------------------

    initial
    begin
        logic [31:0] r;

        reset        <= 1'b1;
        host_valid   <= 1'b0;
        host_data    <= 8'h00;
        host_last    <= 1'b0;
        test_end     <= 1'b0;
        test_id      <= 0;
        credits_used = 0;
        rng_state    = 32'hf1c8_b71c;

        repeat (2) @(posedge clock);
        reset <= 1'b0;
        repeat (8) @(posedge clock);
        finish_test(1);

        for (int f = 0; f < random_frames; f++)
        begin
            r = rand_next();
            send_frame(int'(r % fifo_depth) + 1, 1'b1);
        end
        finish_test(2);

        for (int f = 0; f < burst_frames; f++)
            send_frame(fifo_depth, 1'b0);             // fills the store
        finish_test(3);

        for (int f = 0; f < short_frames; f++)
        begin
            r = rand_next();
            send_frame(int'(r % 8) + 1, 1'b0);        // several frames queued at once
        end
        finish_test(4);

        $display("tests 4, frames checked %0d of %0d, errors %0d",
                 frames_checked, total_frames, error_count);
        if (error_count == 0 && frames_checked == total_frames)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/gmii_tx_mac.sv ====
`default_nettype none

module gmii_tx_mac #(
    parameter int fifo_depth = 32,                    // store size, power of two
    parameter int gap_cycles = 12                     // interframe gap in cycles
) (
    input  wire                   clock,
    input  wire                   reset,

    // host side
    input  wire                   host_valid,
    input  tx_pipe_pkg::tx_byte_t host_data,
    input  wire                   host_last,
    output logic                  credit_return,

    // GMII transmit
    output tx_pipe_pkg::tx_byte_t tx_data,
    output logic                  tx_en
);

    //----------------------------------------------------------------------
    // store -> sequencer -> FCS inserter
    //----------------------------------------------------------------------

    tx_pipe_pkg::tx_byte_t    head_data;
    logic                     head_last;
    logic                     frame_ready;
    logic                     pop;
    tx_pipe_pkg::stage_kind_t stage_kind;
    tx_pipe_pkg::tx_byte_t    stage_data;

    tx_byte_store #(
        .fifo_depth    (fifo_depth)
    ) i_store (
        .clock         (clock),
        .reset         (reset),
        .host_valid    (host_valid),
        .host_data     (host_data),
        .host_last     (host_last),
        .credit_return (credit_return),
        .pop           (pop),
        .head_data     (head_data),
        .head_last     (head_last),
        .frame_ready   (frame_ready)
    );

    tx_frame_sequencer #(
        .gap_cycles    (gap_cycles)
    ) i_sequencer (
        .clock         (clock),
        .reset         (reset),
        .frame_ready   (frame_ready),
        .head_data     (head_data),
        .head_last     (head_last),
        .pop           (pop),
        .stage_kind    (stage_kind),
        .stage_data    (stage_data)
    );

    tx_fcs_inserter i_fcs (
        .clock         (clock),
        .reset         (reset),
        .stage_kind    (stage_kind),
        .stage_data    (stage_data),
        .tx_data       (tx_data),
        .tx_en         (tx_en)
    );

endmodule

`default_nettype wire

// ==== verilog/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

    //----------------------------------------------------------------------
    // frame layout on the GMII side
    //----------------------------------------------------------------------

    localparam logic [7:0] preamble_byte = 8'h55;     // sent preamble_count times
    localparam logic [7:0] sfd_byte      = 8'hd5;     // start frame delimiter

    localparam int preamble_count = 7;                // bytes before the delimiter
    localparam int fcs_bytes      = 4;                // frame check sequence length

    //----------------------------------------------------------------------
    // CRC-32 as used by the Ethernet FCS
    //----------------------------------------------------------------------

    // the running value is kept in reflected form, so bit 0 is the
    // first bit on the wire; the FCS is the complement, low byte first

    localparam logic [31:0] crc_init = 32'hffff_ffff;

    // 0x04C11DB7 with its bit order reversed
    localparam logic [31:0] crc_poly_rev = 32'hedb8_8320;

    // one byte folded into the CRC, lsb first
    function automatic logic [31:0] crc32_next(
        input logic [7:0]  data,
        input logic [31:0] crc
    );
        logic [31:0] c;

        c = crc ^ {24'h000000, data};                 // byte enters at the low end
        for (int i = 0; i < 8; i++)
        begin
            if (c[0])
                c = (c >> 1) ^ crc_poly_rev;          // feedback tap
            else
                c = c >> 1;
        end
        return c;
    endfunction

    // residue check would use 0xdebb20e3; the transmit side has no use for it

endpackage

`default_nettype wire

// ==== verilog/tx_byte_store.sv ====
`default_nettype none

module tx_byte_store #(
    parameter int fifo_depth = 32                     // bytes, power of two
) (
    input  wire                   clock,
    input  wire                   reset,

    input  wire                   host_valid,
    input  tx_pipe_pkg::tx_byte_t host_data,
    input  wire                   host_last,
    output logic                  credit_return,

    input  wire                   pop,
    output tx_pipe_pkg::tx_byte_t head_data,
    output logic                  head_last,
    output logic                  frame_ready
);

    localparam int addr_bits = $clog2(fifo_depth);

    //----------------------------------------------------------------------
    // storage
    //----------------------------------------------------------------------

    tx_pipe_pkg::tx_byte_t data_mem [fifo_depth];
    logic                  last_mem [fifo_depth];

    // pointers carry one extra wrap bit so full and empty differ
    logic [addr_bits:0] wr_ptr;
    logic [addr_bits:0] rd_ptr;
    logic [addr_bits:0] frame_count;                  // complete frames held

    always_ff @(posedge clock)
    begin
        if (host_valid)
        begin
            data_mem[wr_ptr[addr_bits-1:0]] <= host_data;
            last_mem[wr_ptr[addr_bits-1:0]] <= host_last;
        end
    end

    // head of the queue, valid the cycle after a pop
    assign head_data = data_mem[rd_ptr[addr_bits-1:0]];
    assign head_last = last_mem[rd_ptr[addr_bits-1:0]];

    assign frame_ready = (frame_count != '0);

    //----------------------------------------------------------------------
    // pointers, frame count, credits
    //----------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            frame_count   <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (host_valid)
                wr_ptr <= wr_ptr + 1'b1;              // host holds a credit, no full check
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({host_valid && host_last, pop && head_last})
                2'b10:   frame_count <= frame_count + 1'b1;
                2'b01:   frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;  // none, or one in and one out
            endcase

            credit_return <= pop;                     // slot freed one cycle after pop
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tx_fcs_inserter.sv ====
`default_nettype none

module tx_fcs_inserter (
    input  wire                         clock,
    input  wire                         reset,

    input  tx_pipe_pkg::stage_kind_t    stage_kind,
    input  tx_pipe_pkg::tx_byte_t       stage_data,

    output tx_pipe_pkg::tx_byte_t       tx_data,
    output logic                        tx_en
);

    localparam int index_bits = $clog2(mac_pkg::fcs_bytes);

    logic [31:0]           crc;                       // reflected running value
    logic [index_bits-1:0] fcs_index;                 // which FCS byte goes next
    tx_pipe_pkg::tx_byte_t fcs_byte;

    // complemented CRC, low byte first
    assign fcs_byte = ~crc[8*fcs_index +: 8];

    //----------------------------------------------------------------------
    // control
    //----------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            tx_en     <= 1'b0;
            fcs_index <= '0;
        end
        else
        begin
            tx_en <= (stage_kind != tx_pipe_pkg::kind_idle);

            if (stage_kind == tx_pipe_pkg::kind_header)
                fcs_index <= '0;
            else if (stage_kind == tx_pipe_pkg::kind_fcs_slot)
                fcs_index <= fcs_index + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // CRC and output byte
    //----------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        case (stage_kind)
            tx_pipe_pkg::kind_header:
                crc <= mac_pkg::crc_init;             // restarts on every header byte
            tx_pipe_pkg::kind_payload:
                crc <= mac_pkg::crc32_next(stage_data, crc);
            default:
                crc <= crc;                           // held through the FCS slots
        endcase

        if (stage_kind == tx_pipe_pkg::kind_fcs_slot)
            tx_data <= fcs_byte;
        else
            tx_data <= stage_data;
    end

endmodule

`default_nettype wire

// ==== verilog/tx_frame_sequencer.sv ====
`default_nettype none

module tx_frame_sequencer #(
    parameter int gap_cycles = 12                     // minimum idle cycles after a frame
) (
    input  wire                         clock,
    input  wire                         reset,

    input  wire                         frame_ready,
    input  tx_pipe_pkg::tx_byte_t       head_data,
    input  wire                         head_last,
    output logic                        pop,

    output tx_pipe_pkg::stage_kind_t    stage_kind,
    output tx_pipe_pkg::tx_byte_t       stage_data
);

    localparam int count_bits = $clog2(gap_cycles + mac_pkg::preamble_count + 1);

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_preamble  = 3'd1;
    localparam logic [2:0] st_delimiter = 3'd2;
    localparam logic [2:0] st_payload   = 3'd3;
    localparam logic [2:0] st_fcs       = 3'd4;
    localparam logic [2:0] st_gap       = 3'd5;

    logic [2:0]            state;
    logic [count_bits-1:0] count;                     // shared by preamble, fcs and gap

    //----------------------------------------------------------------------
    // state machine
    //----------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= st_idle;
            count <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (frame_ready)
                    begin
                        state <= st_preamble;
                        count <= '0;
                    end
                st_preamble:
                    if (count == count_bits'(mac_pkg::preamble_count - 1))
                        state <= st_delimiter;
                    else
                        count <= count + 1'b1;
                st_delimiter:
                    state <= st_payload;
                st_payload:
                    if (head_last)                    // last byte popped this cycle
                    begin
                        state <= st_fcs;
                        count <= '0;
                    end
                st_fcs:
                    if (count == count_bits'(mac_pkg::fcs_bytes - 1))
                    begin
                        state <= st_gap;
                        count <= '0;
                    end
                    else
                        count <= count + 1'b1;
                st_gap:
                    if (count == count_bits'(gap_cycles - 1))
                        state <= st_idle;
                    else
                        count <= count + 1'b1;
                default:
                    state <= st_idle;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // stage word, decoded from the state
    //----------------------------------------------------------------------

    assign pop = (state == st_payload);               // one byte per payload cycle

    always_comb
    begin
        stage_kind = tx_pipe_pkg::kind_idle;
        stage_data = 8'h00;
        case (state)
            st_preamble:
            begin
                stage_kind = tx_pipe_pkg::kind_header;
                stage_data = mac_pkg::preamble_byte;
            end
            st_delimiter:
            begin
                stage_kind = tx_pipe_pkg::kind_header;
                stage_data = mac_pkg::sfd_byte;
            end
            st_payload:
            begin
                stage_kind = tx_pipe_pkg::kind_payload;
                stage_data = head_data;
            end
            st_fcs:
                stage_kind = tx_pipe_pkg::kind_fcs_slot;  // byte filled in downstream
            default:
                stage_kind = tx_pipe_pkg::kind_idle;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/tx_pipe_pkg.sv ====
`default_nettype none

package tx_pipe_pkg;

    //----------------------------------------------------------------------
    // data carried between the transmit stages
    //----------------------------------------------------------------------

    typedef logic [7:0] tx_byte_t;                    // one GMII byte

    // what the sequencer puts in the stage word this cycle
    typedef enum logic [1:0] {
        kind_idle     = 2'd0,                         // nothing on the line
        kind_header   = 2'd1,                         // preamble or delimiter
        kind_payload  = 2'd2,                         // frame data, goes into the CRC
        kind_fcs_slot = 2'd3                          // filled with an FCS byte downstream
    } stage_kind_t;

endpackage

`default_nettype wire
